//--- src/dma_pkg.sv
package dma_pkg;

  // bus data and address width
  localparam int unsigned DATA_W = 32;

  ////////////////////////////////////////
  // descriptor layout, byte offsets
  ////////////////////////////////////////
  localparam int unsigned DESC_SRC     = 0;
  localparam int unsigned DESC_DST     = 4;
  localparam int unsigned DESC_LEN     = 8;
  localparam int unsigned DESC_SSTRIDE = 12;
  localparam int unsigned DESC_DSTRIDE = 16;
  localparam int unsigned DESC_SWAP    = 20;
  localparam int unsigned DESC_CTRL    = 24;
  localparam int unsigned DESC_STATUS  = 28;

  // configuration words read before the status write
  localparam int unsigned DESC_FETCH_WORDS = 7;

  // swap word flags, two-byte swap wins over four-byte swap
  localparam int unsigned SWAP2_BIT = 1;
  localparam int unsigned SWAP4_BIT = 2;

  // control word
  localparam int unsigned CTRL_START_BIT = 0;

  // configuration port word indices
  localparam int unsigned CONF_IDX_DESC   = 0;
  localparam int unsigned CONF_IDX_STATUS = 1;

  ////////////////////////////////////////
  // bus structs
  ////////////////////////////////////////

  // request toward memory, held until gnt
  typedef struct packed {
    logic              req;
    logic              we;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  // response from memory
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // software access to the register block
  typedef struct packed {
    logic              en;
    logic              we;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } conf_req_t;

  // fetched transfer configuration
  typedef struct packed {
    logic [DATA_W-1:0] src;
    logic [DATA_W-1:0] dst;
    logic [DATA_W-1:0] len;
    logic [DATA_W-1:0] sstride;
    logic [DATA_W-1:0] dstride;
    logic [DATA_W-1:0] swap;
    logic              start;
  } dma_cfg_t;

endpackage

//--- src/dma_conf_regs.sv
`timescale 1ns/1ps

module dma_conf_regs #(
  parameter int unsigned LenWidth = 16
) (
  input  logic                                          clk_i,
  input  logic                                          pause_for_reset_check,
  input  dma_pkg::conf_req_t                            conf_i,
  output logic [dma_pkg::DATA_W-1:0]                    conf_rdata_o,
  output logic                                          fetch_go_o,
  output logic [dma_pkg::DATA_W-1:0]                    desc_addr_o,
  input  logic                                          word_valid_i,
  input  logic [$clog2(dma_pkg::DESC_FETCH_WORDS)-1:0]  word_idx_i,
  input  logic [dma_pkg::DATA_W-1:0]                    word_data_i,
  input  logic                                          fetch_done_i,
  output dma_pkg::dma_cfg_t                             cfg_o,
  output logic                                          copy_go_o,
  input  logic                                          copy_done_i
);

  localparam int unsigned IdxW = $clog2(dma_pkg::DESC_FETCH_WORDS);

  logic                       busy_q;
  logic                       done_q;
  logic                       fetch_go_q;
  logic                       copy_go_q;
  logic [dma_pkg::DATA_W-1:0] desc_addr_q;
  dma_pkg::dma_cfg_t          cfg_q;
  logic [dma_pkg::DATA_W-1:0] conf_idx;
  logic                       desc_wr;
  logic [IdxW+1:0]            word_off;

  // byte address on the port, word index for decode
  assign conf_idx = conf_i.addr >> 2;
  // new descriptor only taken while the engine is quiet
  assign desc_wr  = conf_i.en & conf_i.we & (conf_idx == dma_pkg::CONF_IDX_DESC) & ~busy_q;
  // fetched word index back to descriptor byte offset
  assign word_off = {word_idx_i, 2'b00};

  ////////////////////////////////////////
  // busy / done and launch pulses
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (pause_for_reset_check) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      fetch_go_q <= 1'b0;
      copy_go_q  <= 1'b0;
    end else begin
      fetch_go_q <= desc_wr;
      // copy only follows a completed fetch with start set
      copy_go_q  <= fetch_done_i & cfg_q.start;
      if (desc_wr) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end
      // no start bit, finished right after the status write
      if (fetch_done_i & ~cfg_q.start) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      if (copy_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // descriptor pointer
  always_ff @(posedge clk_i) begin
    if (desc_wr) begin
      desc_addr_q <= conf_i.wdata;
    end
  end

  // fetched words land in their field by offset
  always_ff @(posedge clk_i) begin
    if (word_valid_i) begin
      case (word_off)
        dma_pkg::DESC_SRC:     cfg_q.src     <= word_data_i;
        dma_pkg::DESC_DST:     cfg_q.dst     <= word_data_i;
        // length limited to the counter width
        dma_pkg::DESC_LEN:     cfg_q.len     <= {{(dma_pkg::DATA_W-LenWidth){1'b0}},
                                                 word_data_i[LenWidth-1:0]};
        dma_pkg::DESC_SSTRIDE: cfg_q.sstride <= word_data_i;
        dma_pkg::DESC_DSTRIDE: cfg_q.dstride <= word_data_i;
        dma_pkg::DESC_SWAP:    cfg_q.swap    <= word_data_i;
        dma_pkg::DESC_CTRL:    cfg_q.start   <= word_data_i[dma_pkg::CTRL_START_BIT];
        default: ;
      endcase
    end
  end

  // read side, no wait state
  always_comb begin
    conf_rdata_o = '0;
    if (conf_idx == dma_pkg::CONF_IDX_DESC) begin
      conf_rdata_o = desc_addr_q;
    end else if (conf_idx == dma_pkg::CONF_IDX_STATUS) begin
      // bit 0 busy, bit 1 done
      conf_rdata_o[0] = busy_q;
      conf_rdata_o[1] = done_q;
    end
  end

  assign fetch_go_o  = fetch_go_q;
  assign desc_addr_o = desc_addr_q;
  assign cfg_o       = cfg_q;
  assign copy_go_o   = copy_go_q;

endmodule

//--- src/dma_desc_fetch.sv
`timescale 1ns/1ps

module dma_desc_fetch (
  input  logic                                          clk_i,
  input  logic                                          pause_for_reset_check,
  input  logic                                          fetch_go_i,
  input  logic [dma_pkg::DATA_W-1:0]                    desc_addr_i,
  output dma_pkg::mem_req_t                             mem_req_o,
  input  dma_pkg::mem_rsp_t                             mem_rsp_i,
  output logic                                          word_valid_o,
  output logic [$clog2(dma_pkg::DESC_FETCH_WORDS)-1:0]  word_idx_o,
  output logic [dma_pkg::DATA_W-1:0]                    word_data_o,
  output logic                                          fetch_done_o
);

  localparam int unsigned IdxW = $clog2(dma_pkg::DESC_FETCH_WORDS);
  localparam logic [IdxW-1:0] LastIdx = IdxW'(dma_pkg::DESC_FETCH_WORDS - 1);

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT,
    FETCH_STATUS
  } fetch_state_e;

  fetch_state_e               state_q;
  fetch_state_e               state_d;
  logic [IdxW-1:0]            cnt_q;
  logic [IdxW-1:0]            cnt_d;
  logic [dma_pkg::DATA_W-1:0] word_addr;

  // descriptor base plus four bytes per word already read
  assign word_addr = desc_addr_i + {{(dma_pkg::DATA_W-IdxW-2){1'b0}}, cnt_q, 2'b00};

  // fetched word goes straight out with its index
  assign word_idx_o  = cnt_q;
  assign word_data_o = mem_rsp_i.rdata;

  always_ff @(posedge clk_i) begin
    if (pause_for_reset_check) begin
      state_q <= FETCH_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  ////////////////////////////////////////
  // read words, then write status
  ////////////////////////////////////////
  always_comb begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    mem_req_o    = '0;
    word_valid_o = 1'b0;
    fetch_done_o = 1'b0;
    case (state_q)
      FETCH_IDLE: begin
        if (fetch_go_i) begin
          cnt_d   = '0;
          state_d = FETCH_REQ;
        end
      end
      FETCH_REQ: begin
        // held until granted
        mem_req_o.req  = 1'b1;
        mem_req_o.addr = word_addr;
        if (mem_rsp_i.gnt) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        // exactly one rvalid per granted read
        if (mem_rsp_i.rvalid) begin
          word_valid_o = 1'b1;
          if (cnt_q == LastIdx) begin
            state_d = FETCH_STATUS;
          end else begin
            cnt_d   = cnt_q + 1'b1;
            state_d = FETCH_REQ;
          end
        end
      end
      FETCH_STATUS: begin
        // done word into the descriptor status field
        mem_req_o.req   = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = desc_addr_i + dma_pkg::DESC_STATUS;
        mem_req_o.wdata = 32'd1;
        // write completes at grant
        if (mem_rsp_i.gnt) begin
          fetch_done_o = 1'b1;
          state_d      = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

endmodule

//--- src/dma_copy_engine.sv
`timescale 1ns/1ps

module dma_copy_engine #(
  parameter int unsigned LenWidth = 16
) (
  input  logic               clk_i,
  input  logic               pause_for_reset_check,
  input  dma_pkg::dma_cfg_t  cfg_i,
  input  logic               copy_go_i,
  output dma_pkg::mem_req_t  mem_req_o,
  input  dma_pkg::mem_rsp_t  mem_rsp_i,
  output logic               irq_o,
  output logic               copy_done_o
);

  typedef enum logic [2:0] {
    CP_IDLE,
    CP_REQ,
    CP_WAIT,
    CP_SEND,
    CP_AGEN
  } copy_state_e;

  copy_state_e                state_q;
  copy_state_e                state_d;
  // bytes moved so far
  logic [LenWidth-1:0]        cnt_q;
  logic [dma_pkg::DATA_W-1:0] cnt_ext;
  logic [dma_pkg::DATA_W-1:0] src_off_q;
  logic [dma_pkg::DATA_W-1:0] dst_off_q;
  // read word waits here for the write
  logic [dma_pkg::DATA_W-1:0] rdata_q;
  logic [dma_pkg::DATA_W-1:0] wr_data;
  logic                       last;

  assign cnt_ext = {{(dma_pkg::DATA_W-LenWidth){1'b0}}, cnt_q};
  assign last    = (cnt_q == cfg_i.len[LenWidth-1:0]);

  ////////////////////////////////////////
  // byte swap on the write path
  ////////////////////////////////////////
  always_comb begin
    if (cfg_i.swap[dma_pkg::SWAP2_BIT]) begin
      // low half exchanged, upper half cleared
      wr_data = {16'b0, rdata_q[7:0], rdata_q[15:8]};
    end else if (cfg_i.swap[dma_pkg::SWAP4_BIT]) begin
      wr_data = {rdata_q[7:0], rdata_q[15:8], rdata_q[23:16], rdata_q[31:24]};
    end else begin
      wr_data = rdata_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pause_for_reset_check) begin
      state_q <= CP_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == CP_IDLE && copy_go_i) begin
        cnt_q <= '0;
      end else if (state_q == CP_SEND && mem_rsp_i.gnt) begin
        // one word per pass
        cnt_q <= cnt_q + LenWidth'(4);
      end
    end
  end

  // offsets and read word
  always_ff @(posedge clk_i) begin
    if (state_q == CP_IDLE && copy_go_i) begin
      src_off_q <= '0;
      dst_off_q <= '0;
    end else if (state_q == CP_AGEN) begin
      // multiply kept in its own cycle, away from the bus
      src_off_q <= cnt_ext * (cfg_i.sstride + 1'b1);
      dst_off_q <= cnt_ext * (cfg_i.dstride + 1'b1);
    end
    if (state_q == CP_WAIT && mem_rsp_i.rvalid) begin
      rdata_q <= mem_rsp_i.rdata;
    end
  end

  ////////////////////////////////////////
  // copy FSM
  ////////////////////////////////////////
  always_comb begin
    state_d     = state_q;
    mem_req_o   = '0;
    irq_o       = 1'b0;
    copy_done_o = 1'b0;
    case (state_q)
      CP_IDLE: begin
        if (copy_go_i) begin
          state_d = CP_REQ;
        end
      end
      CP_REQ: begin
        if (last) begin
          // single cycle completion
          irq_o       = 1'b1;
          copy_done_o = 1'b1;
          state_d     = CP_IDLE;
        end else begin
          mem_req_o.req  = 1'b1;
          mem_req_o.addr = cfg_i.src + src_off_q;
          if (mem_rsp_i.gnt) begin
            state_d = CP_WAIT;
          end
        end
      end
      CP_WAIT: begin
        if (mem_rsp_i.rvalid) begin
          state_d = CP_SEND;
        end
      end
      CP_SEND: begin
        mem_req_o.req   = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = cfg_i.dst + dst_off_q;
        mem_req_o.wdata = wr_data;
        if (mem_rsp_i.gnt) begin
          state_d = CP_AGEN;
        end
      end
      CP_AGEN: state_d = CP_REQ;
      default: state_d = CP_IDLE;
    endcase
  end

endmodule

//--- src/dma_top.sv
`timescale 1ns/1ps

module dma_top #(
  parameter int unsigned LenWidth = 16
) (
  input  logic                       clk_i,
  input  logic                       pause_for_reset_check,
  input  dma_pkg::conf_req_t         conf_i,
  output logic [dma_pkg::DATA_W-1:0] conf_rdata_o,
  output dma_pkg::mem_req_t          mem_req_o,
  input  dma_pkg::mem_rsp_t          mem_rsp_i,
  output logic                       irq_o
);

  localparam int unsigned IdxW = $clog2(dma_pkg::DESC_FETCH_WORDS);

  // register block to fetch unit
  logic                       fetch_go;
  logic [dma_pkg::DATA_W-1:0] desc_addr;
  logic                       word_valid;
  logic [IdxW-1:0]            word_idx;
  logic [dma_pkg::DATA_W-1:0] word_data;
  logic                       fetch_done;
  // register block to copy engine
  dma_pkg::dma_cfg_t          cfg;
  logic                       copy_go;
  logic                       copy_done;
  // per-block bus requests
  dma_pkg::mem_req_t          fetch_req;
  dma_pkg::mem_req_t          copy_req;

  dma_conf_regs #(
    .LenWidth (LenWidth)
  ) u_conf_regs (
    .clk_i                 (clk_i),
    .pause_for_reset_check (pause_for_reset_check),
    .conf_i                (conf_i),
    .conf_rdata_o          (conf_rdata_o),
    .fetch_go_o            (fetch_go),
    .desc_addr_o           (desc_addr),
    .word_valid_i          (word_valid),
    .word_idx_i            (word_idx),
    .word_data_i           (word_data),
    .fetch_done_i          (fetch_done),
    .cfg_o                 (cfg),
    .copy_go_o             (copy_go),
    .copy_done_i           (copy_done)
  );

  dma_desc_fetch u_desc_fetch (
    .clk_i                 (clk_i),
    .pause_for_reset_check (pause_for_reset_check),
    .fetch_go_i            (fetch_go),
    .desc_addr_i           (desc_addr),
    .mem_req_o             (fetch_req),
    .mem_rsp_i             (mem_rsp_i),
    .word_valid_o          (word_valid),
    .word_idx_o            (word_idx),
    .word_data_o           (word_data),
    .fetch_done_o          (fetch_done)
  );

  dma_copy_engine #(
    .LenWidth (LenWidth)
  ) u_copy_engine (
    .clk_i                 (clk_i),
    .pause_for_reset_check (pause_for_reset_check),
    .cfg_i                 (cfg),
    .copy_go_i             (copy_go),
    .mem_req_o             (copy_req),
    .mem_rsp_i             (mem_rsp_i),
    .irq_o                 (irq_o),
    .copy_done_o           (copy_done)
  );

  // fetch and copy never overlap, whichever asks owns the bus
  assign mem_req_o = fetch_req.req ? fetch_req : copy_req;

endmodule

//--- verif/dma_sva.sv
`timescale 1ns/1ps

module dma_sva (
  input logic              clk_i,
  input logic              pause_for_reset_check,
  input dma_pkg::mem_req_t mem_req_i,
  input dma_pkg::mem_rsp_t mem_rsp_i,
  input logic              irq_i
);

  // failures so far, the testbench reads this at the end
  int unsigned fail_cnt = 0;
  // a granted read of this engine still waits for rvalid
  logic        rd_out_q;

  always_ff @(posedge clk_i) begin
    if (pause_for_reset_check) begin
      rd_out_q <= 1'b0;
    end else if (mem_req_i.req && !mem_req_i.we && mem_rsp_i.gnt) begin
      rd_out_q <= 1'b1;
    end else if (mem_rsp_i.rvalid) begin
      rd_out_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // bus and interrupt rules
  ////////////////////////////////////////

  // request fields frozen until the grant
  req_stable_a: assert property (@(posedge clk_i) disable iff (pause_for_reset_check)
    mem_req_i.req && !mem_rsp_i.gnt |=> mem_req_i.req && $stable(mem_req_i))
    else begin
      $error("copy request changed before its grant");
      fail_cnt = fail_cnt + 1;
    end

  // completion is a single pulse
  irq_pulse_a: assert property (@(posedge clk_i) disable iff (pause_for_reset_check)
    irq_i |=> !irq_i)
    else begin
      $error("irq high for two cycles in a row");
      fail_cnt = fail_cnt + 1;
    end

  // one access at a time
  one_access_a: assert property (@(posedge clk_i) disable iff (pause_for_reset_check)
    rd_out_q |-> !mem_req_i.req)
    else begin
      $error("copy request raised while a read is outstanding");
      fail_cnt = fail_cnt + 1;
    end

endmodule

//--- verif/dma_tb.sv
`timescale 1ns/1ps

module dma_tb;

  localparam int unsigned MEM_WORDS  = 1024;
  localparam int          WAIT_LIMIT = 5000;
  localparam logic [31:0] STATUS_ADDR = dma_pkg::CONF_IDX_STATUS * 4;

  logic                clk_i = 1'b0;
  logic                pause_for_reset_check;
  dma_pkg::conf_req_t  conf_i;
  logic [31:0]         conf_rdata;
  dma_pkg::mem_req_t   mem_req;
  dma_pkg::mem_rsp_t   mem_rsp = '0;
  logic                irq;

  // memory model state
  logic [31:0]         mem [0:MEM_WORDS-1];
  logic                poke_en;
  logic [31:0]         poke_addr;
  logic [31:0]         poke_data;
  logic                rand_en;
  logic [15:0]         lfsr_q;
  logic                waiting;
  logic [1:0]          gw_cnt;
  logic                rd_pending;
  logic [1:0]          rv_cnt;
  logic [9:0]          rd_idx;

  always #4 clk_i = ~clk_i;

  dma_top #(
    .LenWidth (16)
  ) uut (
    .clk_i                 (clk_i),
    .pause_for_reset_check (pause_for_reset_check),
    .conf_i                (conf_i),
    .conf_rdata_o          (conf_rdata),
    .mem_req_o             (mem_req),
    .mem_rsp_i             (mem_rsp),
    .irq_o                 (irq)
  );

  bind dma_copy_engine dma_sva u_copy_sva (
    .clk_i                 (clk_i),
    .pause_for_reset_check (pause_for_reset_check),
    .mem_req_i             (mem_req_o),
    .mem_rsp_i             (mem_rsp_i),
    .irq_i                 (irq_o)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // every word differs, depends on the whole byte address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h3C5A_0F96;
  endfunction

  function automatic logic [9:0] mem_idx(input logic [31:0] addr);
    return addr[11:2];
  endfunction

  // galois shift right, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic next_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  // target word from source word, two-byte swap wins
  function automatic logic [31:0] swap_expect(input logic [31:0] w, input logic [31:0] swap);
    if (swap[dma_pkg::SWAP2_BIT]) begin
      return {16'h0000, w[7:0], w[15:8]};
    end else if (swap[dma_pkg::SWAP4_BIT]) begin
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
    return w;
  endfunction

  ////////////////////////////////////////
  // memory model, one access in flight
  ////////////////////////////////////////
  always @(posedge clk_i) begin : mem_model
    int          i;
    logic        b0;
    logic        b1;
    logic [1:0]  gdelay;
    if (pause_for_reset_check) begin
      for (i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= fill_word(32'(i) << 2);
      end
      lfsr_q     = 16'd3844;
      mem_rsp    <= '0;
      waiting    <= 1'b0;
      rd_pending <= 1'b0;
    end else begin
      mem_rsp.gnt    <= 1'b0;
      mem_rsp.rvalid <= 1'b0;
      if (poke_en) begin
        mem[mem_idx(poke_addr)] <= poke_data;
      end
      if (rd_pending) begin
        if (rv_cnt <= 2'd1) begin
          mem_rsp.rvalid <= 1'b1;
          mem_rsp.rdata  <= mem[rd_idx];
          rd_pending     <= 1'b0;
        end else begin
          rv_cnt <= rv_cnt - 2'd1;
        end
      end else if (mem_req.req && mem_rsp.gnt) begin
        // access takes place at the granting edge
        if (mem_req.we) begin
          mem[mem_idx(mem_req.addr)] <= mem_req.wdata;
        end else begin
          b0 = 1'b0;
          if (rand_en) begin
            next_bit(b0);
          end
          rd_pending <= 1'b1;
          rd_idx     <= mem_idx(mem_req.addr);
          rv_cnt     <= {1'b0, b0} + 2'd1;
        end
      end else if (mem_req.req) begin
        if (!waiting) begin
          gdelay = 2'd0;
          if (rand_en) begin
            next_bit(b0);
            next_bit(b1);
            gdelay = {b1, b0};
          end
          if (gdelay == 2'd0) begin
            mem_rsp.gnt <= 1'b1;
          end else begin
            waiting <= 1'b1;
            gw_cnt  <= gdelay;
          end
        end else if (gw_cnt == 2'd1) begin
          mem_rsp.gnt <= 1'b1;
          waiting     <= 1'b0;
        end else begin
          gw_cnt <= gw_cnt - 2'd1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Verification failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // backdoor write into the memory model
  task automatic mem_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    poke_en   <= 1'b1;
    poke_addr <= addr;
    poke_data <= data;
    @(posedge clk_i);
    poke_en   <= 1'b0;
  endtask

  task automatic conf_write(input logic [31:0] idx, input logic [31:0] data);
    @(posedge clk_i);
    conf_i.en    <= 1'b1;
    conf_i.we    <= 1'b1;
    conf_i.addr  <= idx << 2;
    conf_i.wdata <= data;
    @(posedge clk_i);
    // park on the status word for the wait loops
    conf_i.en    <= 1'b0;
    conf_i.we    <= 1'b0;
    conf_i.addr  <= STATUS_ADDR;
  endtask

  task automatic conf_read(input logic [31:0] idx, output logic [31:0] data);
    @(posedge clk_i);
    conf_i.en   <= 1'b1;
    conf_i.addr <= idx << 2;
    @(negedge clk_i);
    data = conf_rdata;
    @(posedge clk_i);
    conf_i.en   <= 1'b0;
    conf_i.addr <= STATUS_ADDR;
  endtask

  task automatic write_desc(input logic [31:0] base, input logic [31:0] src,
                            input logic [31:0] dst, input logic [31:0] len,
                            input logic [31:0] ss, input logic [31:0] ds,
                            input logic [31:0] swap, input logic [31:0] ctrl);
    mem_write(base + dma_pkg::DESC_SRC, src);
    mem_write(base + dma_pkg::DESC_DST, dst);
    mem_write(base + dma_pkg::DESC_LEN, len);
    mem_write(base + dma_pkg::DESC_SSTRIDE, ss);
    mem_write(base + dma_pkg::DESC_DSTRIDE, ds);
    mem_write(base + dma_pkg::DESC_SWAP, swap);
    mem_write(base + dma_pkg::DESC_CTRL, ctrl);
    // cleared so the done write shows
    mem_write(base + dma_pkg::DESC_STATUS, 32'h0);
  endtask

  // done bit polled on the status word, irq pulses counted meanwhile
  task automatic wait_done(output int irqs);
    int   cyc;
    logic seen;
    irqs = 0;
    seen = 1'b0;
    for (cyc = 0; cyc < WAIT_LIMIT && !seen; cyc++) begin
      @(negedge clk_i);
      if (irq) begin
        irqs++;
      end
      if (conf_rdata[1]) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      $display("timeout while waiting for the done bit");
      $display("Verification failed");
      $fatal(1, "no completion within %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic run_copy(input logic [31:0] base, input logic [31:0] src,
                          input logic [31:0] dst, input logic [31:0] len,
                          input logic [31:0] ss, input logic [31:0] ds,
                          input logic [31:0] swap, input logic [31:0] ctrl);
    int irqs;
    write_desc(base, src, dst, len, ss, ds, swap, ctrl);
    conf_write(dma_pkg::CONF_IDX_DESC, base);
    wait_done(irqs);
    check_value("irq_count", 32'(irqs), ctrl[dma_pkg::CTRL_START_BIT] ? 32'd1 : 32'd0);
    check_value("desc_status", mem[mem_idx(base + dma_pkg::DESC_STATUS)], 32'd1);
  endtask

  // offset rule c * (stride + 1) for each counter value
  task automatic check_target(input logic [31:0] src, input logic [31:0] dst,
                              input logic [31:0] len, input logic [31:0] ss,
                              input logic [31:0] ds, input logic [31:0] swap);
    logic [31:0] c;
    logic [31:0] a;
    for (c = 0; c < len; c += 4) begin
      a = dst + c * (ds + 1);
      check_value($sformatf("mem[%08h]", a), mem[mem_idx(a)],
                  swap_expect(fill_word(src + c * (ss + 1)), swap));
    end
  endtask

  // words skipped by the target stride keep their fill
  task automatic check_gaps(input logic [31:0] dst, input logic [31:0] len,
                            input logic [31:0] ds);
    logic [31:0] off;
    for (off = 0; off < len * (ds + 1); off += 4) begin
      if (off % (4 * (ds + 1)) != 0) begin
        check_value($sformatf("mem[%08h]", dst + off), mem[mem_idx(dst + off)],
                    fill_word(dst + off));
      end
    end
  endtask

  // target range of a transfer that never ran keeps its fill
  task automatic check_untouched(input logic [31:0] dst, input logic [31:0] len);
    logic [31:0] off;
    for (off = 0; off < len; off += 4) begin
      check_value($sformatf("mem[%08h]", dst + off), mem[mem_idx(dst + off)],
                  fill_word(dst + off));
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic test_contiguous();
    logic [31:0] st;
    run_copy(32'h000, 32'h100, 32'h200, 32'd16, 32'd0, 32'd0, 32'h0, 32'h1);
    check_target(32'h100, 32'h200, 32'd16, 32'd0, 32'd0, 32'h0);
    conf_read(dma_pkg::CONF_IDX_STATUS, st);
    check_value("conf_status", st, 32'h2);
  endtask

  task automatic test_strided();
    run_copy(32'h040, 32'h300, 32'h400, 32'd16, 32'd1, 32'd3, 32'h0, 32'h1);
    check_target(32'h300, 32'h400, 32'd16, 32'd1, 32'd3, 32'h0);
    check_gaps(32'h400, 32'd16, 32'd3);
  endtask

  task automatic test_swap();
    run_copy(32'h060, 32'h500, 32'h600, 32'd16, 32'd0, 32'd0, 32'h2, 32'h1);
    check_target(32'h500, 32'h600, 32'd16, 32'd0, 32'd0, 32'h2);
    run_copy(32'h080, 32'h500, 32'h640, 32'd16, 32'd0, 32'd0, 32'h4, 32'h1);
    check_target(32'h500, 32'h640, 32'd16, 32'd0, 32'd0, 32'h4);
    // both flags, two-byte rule
    run_copy(32'h0A0, 32'h500, 32'h680, 32'd16, 32'd0, 32'd0, 32'h6, 32'h1);
    check_target(32'h500, 32'h680, 32'd16, 32'd0, 32'd0, 32'h6);
  endtask

  task automatic test_no_start();
    logic [31:0] st;
    run_copy(32'h0C0, 32'h500, 32'h700, 32'd16, 32'd0, 32'd0, 32'h0, 32'h0);
    check_untouched(32'h700, 32'd16);
    conf_read(dma_pkg::CONF_IDX_STATUS, st);
    check_value("conf_status", st, 32'h2);
  endtask

  task automatic test_status_busy();
    logic [31:0] st;
    int          irqs;
    write_desc(32'h0E0, 32'h500, 32'h780, 32'd16, 32'd0, 32'd0, 32'h0, 32'h1);
    write_desc(32'h120, 32'h500, 32'h7C0, 32'd16, 32'd0, 32'd0, 32'h0, 32'h1);
    conf_write(dma_pkg::CONF_IDX_DESC, 32'h0E0);
    conf_read(dma_pkg::CONF_IDX_STATUS, st);
    check_value("conf_status", st, 32'h1);
    // second pointer arrives mid transfer
    conf_write(dma_pkg::CONF_IDX_DESC, 32'h120);
    wait_done(irqs);
    check_value("irq_count", 32'(irqs), 32'd1);
    conf_read(dma_pkg::CONF_IDX_STATUS, st);
    check_value("conf_status", st, 32'h2);
    conf_read(dma_pkg::CONF_IDX_DESC, st);
    check_value("conf_desc", st, 32'h0E0);
    check_value("desc2_status", mem[mem_idx(32'h120 + dma_pkg::DESC_STATUS)], 32'h0);
    check_target(32'h500, 32'h780, 32'd16, 32'd0, 32'd0, 32'h0);
    check_untouched(32'h7C0, 32'd16);
  endtask

  task automatic test_random_delays();
    @(posedge clk_i);
    rand_en <= 1'b1;
    run_copy(32'h140, 32'h800, 32'h900, 32'd32, 32'd1, 32'd2, 32'h4, 32'h1);
    check_target(32'h800, 32'h900, 32'd32, 32'd1, 32'd2, 32'h4);
    check_gaps(32'h900, 32'd32, 32'd2);
    @(posedge clk_i);
    rand_en <= 1'b0;
  endtask

  initial begin
    pause_for_reset_check = 1'b1;
    conf_i                = '0;
    poke_en               = 1'b0;
    poke_addr             = '0;
    poke_data             = '0;
    rand_en               = 1'b0;
    repeat (3) @(posedge clk_i);
    pause_for_reset_check <= 1'b0;
    conf_i.addr           <= STATUS_ADDR;
    test_contiguous();
    test_strided();
    test_swap();
    test_no_start();
    test_status_busy();
    test_random_delays();
    repeat (4) @(posedge clk_i);
    if (uut.u_copy_engine.u_copy_sva.fail_cnt == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Verification failed");
      $fatal(1, "copy engine assertions failed");
    end
  end

endmodule

//--- compile.f
src/dma_pkg.sv
src/dma_conf_regs.sv
src/dma_desc_fetch.sv
src/dma_copy_engine.sv
src/dma_top.sv
verif/dma_sva.sv
verif/dma_tb.sv

//--- run.sh
#!/bin/sh
# build and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module dma_tb -o dma_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running after an assertion error so the testbench reaches its verdict
./obj_dir/dma_tb_sim +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
